//--- list.f
+incdir+sim
verilog/pcbus_pkg.sv
verilog/bus_decoder.sv
verilog/main_mem.sv
verilog/io_ports.sv
verilog/irq_ctrl.sv
verilog/rsp_mux.sv
verilog/pc_bus_top.sv
sim/tb_clock.sv
sim/tb_pc_bus.sv

//--- Makefile
# Verilator build and run of the PC bus fabric testbench

VERILATOR ?= verilator
TOP       ?= tb_pc_bus
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

# The run passes only if the pass line shows up in the simulator output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_model.svh
// Reference model of memory, LED latch, read ports and pending interrupts, included by the testbench
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

  logic [15:0] ref_mem [2**MEM_ADR_BITS];
  logic [15:0] led_shadow;
  logic [7:0]  pend_set;

  // Upper address bits alias onto the low word index
  function automatic int word_index(input logic [19:0] adr);
    return int'(adr[MEM_ADR_BITS:1]);
  endfunction

  task automatic mem_store(input logic [19:0] adr, input logic [15:0] wdat,
                           input logic [1:0] sel);
    int i;
    i = word_index(adr);
    if (sel[0]) begin
      ref_mem[i][7:0] = wdat[7:0];
    end
    if (sel[1]) begin
      ref_mem[i][15:8] = wdat[15:8];
    end
  endtask

  function automatic logic [15:0] mem_expect(input logic [19:0] adr);
    return ref_mem[word_index(adr)];
  endfunction

  function automatic bit port_is_mapped(input logic [15:0] port);
    return (port[15:8] == 8'hF1) || (port == 16'h0102) ||
           (port == 16'h0060) || (port == 16'h0064);
  endfunction

  function automatic logic [15:0] io_expect(input logic [15:0] port, input logic [7:0] sw_v,
                                            input logic [7:0] key_v);
    logic [15:0] word;
    case (port)
      16'h0102: word = {8'h00, sw_v};
      16'h0060: word = {8'h00, key_v};
      16'h0064: word = 16'h0010;
      default:  word = 16'hFFFF;
    endcase
    return word;
  endfunction

  task automatic led_store(input logic [15:0] port, input logic [15:0] wdat);
    if (port[15:8] == 8'hF1) begin
      led_shadow = wdat;
    end
  endtask

  task automatic edges_capture(input logic [7:0] prev, input logic [7:0] now);
    pend_set = pend_set | (now & ~prev);
  endtask

  // First pending bit from the bottom gives the vector
  function automatic logic [15:0] vector_expect();
    for (int i = 0; i < 8; i++) begin
      if (pend_set[i]) begin
        return 16'h0008 + 16'(i);
      end
    end
    return 16'h0008;
  endfunction

  task automatic lowest_pending_clear();
    // x & (x - 1) drops the lowest set bit
    pend_set = pend_set & (pend_set - 8'd1);
  endtask

`endif

//--- sim/tb_pc_bus.sv
// Testbench top for the PC bus fabric; random bus cycles checked against a reference model
`timescale 1ns/1ns

module tb_pc_bus;

  localparam int MEM_ADR_BITS = 10;
  localparam int MEM_WAIT     = 2;
  localparam int DRIVE_DELAY  = 1;
  localparam int ACK_TIMEOUT  = 64;
  localparam int RST_TIMEOUT  = 100;

  logic                clk;
  logic                rst_n;
  logic                stb;
  pcbus_pkg::bus_req_t req;
  logic [7:0]          sw;
  logic [7:0]          key;
  logic [7:0]          irq;
  logic                ack;
  logic [15:0]         dat;
  logic [15:0]         led;
  logic                intr;

  string       cur_test;
  int          test_errs;
  int          n_checks;
  int          n_errors;
  int          n_passed;
  int          n_failed;
  int          last_latency;
  logic        ack_after;
  logic [15:0] rdata;
  bit          hung;

  `include "tb_model.svh"

  tb_clock #(.PERIOD(10), .RESET_CYCLES(16)) u_clock (.clk_o(clk), .rst_n_o(rst_n));

  pc_bus_top #(
    .MEM_ADR_BITS (MEM_ADR_BITS),
    .MEM_WAIT     (MEM_WAIT)
  ) uut (
    .clk     (clk),
    .rst_n_i (rst_n),
    .stb_i   (stb),
    .req_i   (req),
    .sw_i    (sw),
    .key_i   (key),
    .irq_i   (irq),
    .ack_o   (ack),
    .dat_o   (dat),
    .led_o   (led),
    .intr_o  (intr)
  );

  task automatic compare_word(input string what, input logic [15:0] exp, input logic [15:0] act);
    if (hung) return;
    n_checks++;
    assert (act === exp) else begin
      $display("Error %s, %s: expected %h, actual %h", cur_test, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic finish_test();
    if (test_errs == 0 && !hung) begin
      n_passed++;
      $display("Test %s: passed", cur_test);
    end else begin
      n_failed++;
      $display("Test %s: failed, %0d errors%s", cur_test, test_errs,
               hung ? ", bus stopped by a timeout" : "");
    end
    n_errors += test_errs;
  endtask

  // One master cycle; strobe held until ack, then dropped for a cycle
  task automatic bus_cycle(input pcbus_pkg::bus_req_t r);
    int cycles;
    if (hung) return;
    req    = r;
    stb    = 1'b1;
    cycles = 0;
    while (ack !== 1'b1 && cycles < ACK_TIMEOUT) begin
      @(posedge clk);
      #(DRIVE_DELAY);
      cycles++;
    end
    stb = 1'b0;
    if (ack !== 1'b1) begin
      hung = 1'b1;
      test_errs++;
      $display("Timeout in %s: no acknowledge within %0d cycles", cur_test, ACK_TIMEOUT);
      return;
    end
    last_latency = cycles;
    rdata        = dat;
    @(posedge clk);
    #(DRIVE_DELAY);
    ack_after = ack;
  endtask

  function automatic pcbus_pkg::bus_req_t mem_req(input logic [19:0] adr, input logic we,
                                                  input logic [15:0] wdat, input logic [1:0] sel);
    pcbus_pkg::bus_req_t r;
    r                 = '0;
    r.adr.mem.word    = adr[19:1];
    r.adr.mem.byte_lo = adr[0];
    r.dat             = wdat;
    r.sel             = sel;
    r.we              = we;
    return r;
  endfunction

  function automatic pcbus_pkg::bus_req_t io_req(input logic [15:0] port, input logic we,
                                                 input logic [15:0] wdat);
    pcbus_pkg::bus_req_t r;
    r               = '0;
    r.adr.io.unused = 4'($urandom());
    r.adr.io.port   = port;
    r.dat           = wdat;
    r.sel           = 2'b11;
    r.we            = we;
    r.tga           = 1'b1;
    return r;
  endfunction

  function automatic pcbus_pkg::bus_req_t inta_req();
    pcbus_pkg::bus_req_t r;
    r      = '0;
    r.tga  = 1'b1;
    r.inta = 1'b1;
    return r;
  endfunction

  function automatic logic [19:0] random_mem_adr(input int idx);
    logic [19:0] adr;
    adr                   = 20'($urandom());
    adr[MEM_ADR_BITS:1]   = MEM_ADR_BITS'(idx);
    return adr;
  endfunction

  function automatic logic [15:0] fill_pattern(input logic [19:0] adr);
    return adr[19:4] ^ (adr[15:0] * 16'h9E37);
  endfunction

  function automatic logic [15:0] pick_unmapped_port();
    logic [15:0] port;
    logic [15:0] cand;
    bit          found;
    port  = 16'h0300;
    found = 1'b0;
    for (int n = 0; n < 16 && !found; n++) begin
      cand = 16'($urandom());
      if (!port_is_mapped(cand)) begin
        port  = cand;
        found = 1'b1;
      end
    end
    return port;
  endfunction

  task automatic reset_state();
    start_test("reset state");
    compare_word("led_o after reset", 16'h0000, led);
    compare_word("intr_o after reset", 16'h0000, 16'(intr));
    compare_word("ack_o after reset", 16'h0000, 16'(ack));
    bus_cycle(inta_req());
    compare_word("vector with nothing pending", vector_expect(), rdata);
    finish_test();
  endtask

  task automatic mem_access();
    logic [19:0] adr;
    logic [19:0] alias_adr;
    logic [15:0] wdat;
    logic [1:0]  sel;
    start_test("memory access");
    // Every word gets a known value first
    for (int i = 0; i < 2**MEM_ADR_BITS; i++) begin
      adr = random_mem_adr(i);
      bus_cycle(mem_req(adr, 1'b1, fill_pattern(adr), 2'b11));
      mem_store(adr, fill_pattern(adr), 2'b11);
    end
    for (int n = 0; n < 400; n++) begin
      adr = 20'($urandom());
      if ($urandom_range(0, 1) == 1) begin
        wdat = 16'($urandom());
        sel  = 2'($urandom_range(1, 3));
        bus_cycle(mem_req(adr, 1'b1, wdat, sel));
        mem_store(adr, wdat, sel);
      end else begin
        bus_cycle(mem_req(adr, 1'b0, 16'h0000, 2'b11));
        compare_word("random read", mem_expect(adr), rdata);
      end
    end
    // Same word seen through different upper address bits
    for (int n = 0; n < 64; n++) begin
      adr           = 20'($urandom());
      alias_adr     = random_mem_adr(word_index(adr));
      alias_adr[19] = ~adr[19];
      bus_cycle(mem_req(adr, 1'b0, 16'h0000, 2'b11));
      compare_word("alias base read", mem_expect(adr), rdata);
      bus_cycle(mem_req(alias_adr, 1'b0, 16'h0000, 2'b11));
      compare_word("aliased read", mem_expect(adr), rdata);
    end
    finish_test();
  endtask

  task automatic mem_latency();
    logic [19:0] adr;
    logic [15:0] wdat;
    logic [1:0]  sel;
    logic        we;
    start_test("memory latency");
    for (int n = 0; n < 24; n++) begin
      adr  = 20'($urandom());
      wdat = 16'($urandom());
      sel  = 2'($urandom_range(1, 3));
      we   = 1'($urandom());
      bus_cycle(mem_req(adr, we, wdat, sel));
      if (we) begin
        mem_store(adr, wdat, sel);
      end else begin
        compare_word("read data", mem_expect(adr), rdata);
      end
      compare_word("ack latency", 16'(2 + MEM_WAIT), 16'(last_latency));
      compare_word("ack one cycle wide", 16'h0000, 16'(ack_after));
    end
    finish_test();
  endtask

  task automatic io_port_access();
    logic [15:0] port;
    logic [15:0] wdat;
    logic [15:0] rd_ports [3];
    rd_ports = '{16'h0102, 16'h0060, 16'h0064};
    start_test("io ports");
    for (int n = 0; n < 12; n++) begin
      port = {8'hF1, 8'($urandom())};
      wdat = 16'($urandom());
      bus_cycle(io_req(port, 1'b1, wdat));
      led_store(port, wdat);
      compare_word("led latch", led_shadow, led);
      compare_word("led write latency", 16'd2, 16'(last_latency));
      sw  = 8'($urandom());
      key = 8'($urandom());
      foreach (rd_ports[i]) begin
        bus_cycle(io_req(rd_ports[i], 1'b0, 16'h0000));
        compare_word($sformatf("port %h read", rd_ports[i]), io_expect(rd_ports[i], sw, key),
                     rdata);
        compare_word("read latency", 16'd2, 16'(last_latency));
      end
      port = pick_unmapped_port();
      bus_cycle(io_req(port, 1'b0, 16'h0000));
      compare_word($sformatf("unmapped port %h read", port), io_expect(port, sw, key), rdata);
      bus_cycle(io_req(port, 1'b1, 16'($urandom())));
      compare_word("led after unmapped write", led_shadow, led);
      compare_word("unmapped write latency", 16'd2, 16'(last_latency));
    end
    finish_test();
  endtask

  task automatic irq_sequence();
    logic [7:0]  v;
    logic [15:0] exp;
    int          n;
    start_test("interrupts");
    for (int round = 0; round < 6; round++) begin
      for (int k = 0; k < 3; k++) begin
        v = 8'($urandom());
        edges_capture(irq, v);
        irq = v;
        @(posedge clk);
        #(DRIVE_DELAY);
        compare_word("intr_o after edges", 16'(pend_set != 8'h00), 16'(intr));
      end
      n = 0;
      while (intr === 1'b1 && n < 9 && !hung) begin
        exp = vector_expect();
        bus_cycle(inta_req());
        lowest_pending_clear();
        compare_word("irq vector", exp, rdata);
        compare_word("intr_o after ack", 16'(pend_set != 8'h00), 16'(intr));
        n++;
      end
      compare_word("pending left after acks", 16'h0000, 16'(pend_set));
    end
    finish_test();
  endtask

  initial begin
    int n;
    void'($urandom(33380));
    stb        = 1'b0;
    req        = '0;
    sw         = 8'h00;
    key        = 8'h00;
    irq        = 8'h00;
    hung       = 1'b0;
    n_checks   = 0;
    n_errors   = 0;
    n_passed   = 0;
    n_failed   = 0;
    led_shadow = 16'h0000;
    pend_set   = 8'h00;
    n          = 0;
    while (rst_n !== 1'b1 && n < RST_TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      hung = 1'b1;
      $display("Reset was not released within %0d cycles", RST_TIMEOUT);
    end
    @(posedge clk);
    #(DRIVE_DELAY);
    reset_state();
    mem_access();
    mem_latency();
    io_port_access();
    irq_sequence();
    $display("Summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
             n_passed, n_failed, n_checks, n_errors);
    if (n_failed == 0 && !hung) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- sim/tb_clock.sv
// Testbench clock and reset source; free-running clock, reset held low for a set number of cycles
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Release lands just after an edge, like the rest of the stimulus
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

//--- verilog/pc_bus_top.sv
// Top of the PC bus fabric; wires the decoder, the three targets and the response mux
`timescale 1ns/1ns

module pc_bus_top #(
  parameter int MEM_ADR_BITS = 10,
  parameter int MEM_WAIT     = 2
) (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                stb_i,
  input  pcbus_pkg::bus_req_t req_i,
  input  logic [7:0]          sw_i,
  input  logic [7:0]          key_i,
  input  logic [7:0]          irq_i,
  output logic                ack_o,
  output logic [15:0]         dat_o,
  output logic [15:0]         led_o,
  output logic                intr_o
);

  pcbus_pkg::dec_req_t dec;
  pcbus_pkg::rsp_t     mem_rsp;
  pcbus_pkg::rsp_t     io_rsp;
  pcbus_pkg::rsp_t     irq_rsp;
  logic                done;

  bus_decoder u_dec (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .stb_i   (stb_i),
    .req_i   (req_i),
    .done_i  (done),
    .dec_o   (dec)
  );

  main_mem #(
    .MEM_ADR_BITS (MEM_ADR_BITS),
    .MEM_WAIT     (MEM_WAIT)
  ) u_mem (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .dec_i   (dec),
    .rsp_o   (mem_rsp)
  );

  io_ports u_io (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .dec_i   (dec),
    .sw_i    (sw_i),
    .key_i   (key_i),
    .led_o   (led_o),
    .rsp_o   (io_rsp)
  );

  irq_ctrl u_irq (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .irq_i   (irq_i),
    .dec_i   (dec),
    .intr_o  (intr_o),
    .rsp_o   (irq_rsp)
  );

  rsp_mux u_mux (
    .dec_i  (dec),
    .mem_i  (mem_rsp),
    .io_i   (io_rsp),
    .irq_i  (irq_rsp),
    .ack_o  (ack_o),
    .dat_o  (dat_o),
    .done_o (done)
  );

endmodule

//--- verilog/rsp_mux.sv
// Output side of the fabric; steers the addressed target's response back to the master
`timescale 1ns/1ns

module rsp_mux (
  input  pcbus_pkg::dec_req_t dec_i,
  input  pcbus_pkg::rsp_t     mem_i,
  input  pcbus_pkg::rsp_t     io_i,
  input  pcbus_pkg::rsp_t     irq_i,
  output logic                ack_o,
  output logic [15:0]         dat_o,
  output logic                done_o
);

  pcbus_pkg::rsp_t pick;
  logic            stray_ack;

  always_comb begin
    case (dec_i.tgt)
      pcbus_pkg::tgt_mem: begin
        pick      = mem_i;
        stray_ack = io_i.ack | irq_i.ack;
      end
      pcbus_pkg::tgt_io: begin
        pick      = io_i;
        stray_ack = mem_i.ack | irq_i.ack;
      end
      pcbus_pkg::tgt_irq: begin
        pick      = irq_i;
        stray_ack = mem_i.ack | io_i.ack;
      end
      default: begin
        // Nothing decodes here, answer with an idle bus
        pick      = '{dat: 16'hFFFF, ack: 1'b0};
        stray_ack = mem_i.ack | io_i.ack | irq_i.ack;
      end
    endcase
  end

  assign ack_o  = pick.ack && dec_i.valid;
  assign dat_o  = pick.dat;
  // Decoder frees up on the same cycle the master sees its ack
  assign done_o = ack_o;

  // Targets only answer the cycle the decoder routed to them
  always_comb begin
    a_one_target: assert (!stray_ack)
      else $error("rsp_mux: ack from a target that was not addressed");
  end

endmodule

//--- verilog/irq_ctrl.sv
// Eight-input interrupt controller; latches rising edges and answers acknowledge cycles with a vector
`timescale 1ns/1ns

module irq_ctrl (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic [7:0]          irq_i,
  input  pcbus_pkg::dec_req_t dec_i,
  output logic                intr_o,
  output pcbus_pkg::rsp_t     rsp_o
);

  logic [7:0]  irq_prev_q;
  logic [7:0]  pend_q;
  logic [7:0]  clr;
  logic [2:0]  low_idx;
  logic        active;
  logic        ack_q;
  logic [15:0] vec_q;

  // Lowest index wins, index 0 when nothing is pending
  always_comb begin
    low_idx = 3'd0;
    for (int i = 7; i >= 0; i--) begin
      if (pend_q[i]) begin
        low_idx = 3'(i);
      end
    end
  end

  assign active = dec_i.valid && (dec_i.tgt == pcbus_pkg::tgt_irq) && !ack_q;
  assign clr    = (active && pend_q[low_idx]) ? (8'd1 << low_idx) : 8'd0;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      irq_prev_q <= 8'h00;
      pend_q     <= 8'h00;
      ack_q      <= 1'b0;
    end else begin
      irq_prev_q <= irq_i;
      // A new edge on the bit being acknowledged stays pending
      pend_q     <= (pend_q & ~clr) | (irq_i & ~irq_prev_q);
      ack_q      <= active;
    end
  end

  always_ff @(posedge clk) begin
    if (active) begin
      vec_q <= pcbus_pkg::irq_vec_base + {13'd0, low_idx};
    end
  end

  assign intr_o = |pend_q;
  assign rsp_o  = '{dat: vec_q, ack: ack_q};

endmodule

//--- verilog/io_ports.sv
// I/O register target; LED latch plus switch and keyboard read ports, unmapped reads give all ones
`timescale 1ns/1ns

module io_ports (
  input  logic                clk,
  input  logic                rst_n_i,
  input  pcbus_pkg::dec_req_t dec_i,
  input  logic [7:0]          sw_i,
  input  logic [7:0]          key_i,
  output logic [15:0]         led_o,
  output pcbus_pkg::rsp_t     rsp_o
);

  logic [15:0] port;
  logic        active;
  logic        led_hit;
  logic        ack_q;
  logic [15:0] rd_q;
  logic [15:0] led_q;
  logic [15:0] rd_word;

  assign port    = dec_i.req.adr.io.port;
  assign active  = dec_i.valid && (dec_i.tgt == pcbus_pkg::tgt_io) && !ack_q;
  // Whole F1xx page maps to the LED latch
  assign led_hit = (port[15:8] == pcbus_pkg::led_port_hi[7:0]);

  always_comb begin
    case (port)
      pcbus_pkg::port_switch:    rd_word = {8'h00, sw_i};
      pcbus_pkg::port_keyb_data: rd_word = {8'h00, key_i};
      pcbus_pkg::port_keyb_stat: rd_word = pcbus_pkg::keyb_stat_value;
      default:                   rd_word = 16'hFFFF;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
      led_q <= 16'h0000;
    end else begin
      // Every I/O cycle gets its ack, mapped or not
      ack_q <= active;
      if (active && dec_i.req.we && led_hit) begin
        led_q <= dec_i.req.dat;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (active) begin
      rd_q <= rd_word;
    end
  end

  assign led_o = led_q;
  assign rsp_o = '{dat: rd_q, ack: ack_q};

endmodule

//--- verilog/main_mem.sv
// Main memory target; word array with byte selects and a fixed number of wait cycles
`timescale 1ns/1ns

module main_mem #(
  parameter int MEM_ADR_BITS = 10,
  parameter int MEM_WAIT     = 2
) (
  input  logic                clk,
  input  logic                rst_n_i,
  input  pcbus_pkg::dec_req_t dec_i,
  output pcbus_pkg::rsp_t     rsp_o
);

  localparam int CNT_W = (MEM_WAIT > 0) ? $clog2(MEM_WAIT + 1) : 1;

  logic [15:0]             mem_q [2**MEM_ADR_BITS];
  logic [MEM_ADR_BITS-1:0] idx;
  logic [CNT_W-1:0]        wait_q;
  logic                    ack_q;
  logic [15:0]             rd_q;
  logic                    active;
  logic                    done_wait;

  // High address bits are ignored, so the array aliases
  assign idx       = dec_i.req.adr.mem.word[MEM_ADR_BITS-1:0];
  assign active    = dec_i.valid && (dec_i.tgt == pcbus_pkg::tgt_mem) && !ack_q;
  assign done_wait = (wait_q == CNT_W'(MEM_WAIT));

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wait_q <= '0;
      ack_q  <= 1'b0;
    end else begin
      ack_q <= active && done_wait;
      if (active && !done_wait) begin
        wait_q <= wait_q + 1'b1;
      end else begin
        wait_q <= '0;
      end
    end
  end

  // Access happens on the acknowledge cycle only
  always_ff @(posedge clk) begin
    if (active && done_wait) begin
      rd_q <= mem_q[idx];
      if (dec_i.req.we && dec_i.req.sel[0]) begin
        mem_q[idx][7:0] <= dec_i.req.dat[7:0];
      end
      if (dec_i.req.we && dec_i.req.sel[1]) begin
        mem_q[idx][15:8] <= dec_i.req.dat[15:8];
      end
    end
  end

  assign rsp_o = '{dat: rd_q, ack: ack_q};

  a_sel_nonzero: assert property (@(posedge clk) disable iff (!rst_n_i)
    (dec_i.valid && dec_i.tgt == pcbus_pkg::tgt_mem && dec_i.req.we) |-> (dec_i.req.sel != 2'b00))
    else $error("main_mem: write cycle with no byte selected");

endmodule

//--- verilog/bus_decoder.sv
// Input side of the fabric; latches one master cycle and tags it with the target it goes to
`timescale 1ns/1ns

module bus_decoder (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               stb_i,
  input  pcbus_pkg::bus_req_t req_i,
  input  logic               done_i,
  output pcbus_pkg::dec_req_t dec_o
);

  logic                valid_q;
  pcbus_pkg::bus_req_t req_q;
  pcbus_pkg::target_e  tgt_q;
  logic                accept;

  // Interrupt acknowledge wins over the space tag
  function automatic pcbus_pkg::target_e classify(input pcbus_pkg::bus_req_t req);
    pcbus_pkg::target_e tgt;
    if (req.inta) begin
      tgt = pcbus_pkg::tgt_irq;
    end else if (!req.tga) begin
      tgt = pcbus_pkg::tgt_mem;
    end else begin
      tgt = pcbus_pkg::tgt_io;
    end
    return tgt;
  endfunction

  // Only take a new cycle when nothing is in flight
  assign accept = stb_i && !valid_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (done_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= req_i;
      tgt_q <= classify(req_i);
    end
  end

  assign dec_o = '{req: req_q, tgt: tgt_q, valid: valid_q};

  // Master must hold the cycle steady until it sees the acknowledge
  property p_req_stable;
    @(posedge clk) disable iff (!rst_n_i)
      (stb_i && !done_i) ##1 stb_i |-> $stable(req_i);
  endproperty

  a_req_stable: assert property (p_req_stable)
    else $error("bus_decoder: req_i changed while stb_i held");

endmodule

//--- verilog/pcbus_pkg.sv
// Shared bus types, address views, target codes and port numbers for the PC bus fabric
package pcbus_pkg;

  // Memory view of the address word: word address plus low byte bit
  typedef struct packed {
    logic [18:0] word;
    logic        byte_lo;
  } mem_adr_t;

  // I/O view: 16-bit port number, top bits not decoded
  typedef struct packed {
    logic [3:0]  unused;
    logic [15:0] port;
  } io_adr_t;

  // The tga bit of the cycle says which view applies
  typedef union packed {
    mem_adr_t mem;
    io_adr_t  io;
  } bus_adr_u;

  typedef struct packed {
    bus_adr_u    adr;
    logic [15:0] dat;
    logic [1:0]  sel;
    logic        we;
    logic        tga;
    logic        inta;
  } bus_req_t;

  typedef enum logic [1:0] {
    tgt_mem,
    tgt_io,
    tgt_irq,
    tgt_none
  } target_e;

  typedef struct packed {
    bus_req_t req;
    target_e  tgt;
    logic     valid;
  } dec_req_t;

  typedef struct packed {
    logic [15:0] dat;
    logic        ack;
  } rsp_t;

  // Fixed I/O map
  localparam logic [15:0] port_keyb_data  = 16'h0060;
  localparam logic [15:0] port_keyb_stat  = 16'h0064;
  localparam logic [15:0] port_switch     = 16'h0102;
  localparam logic [15:0] led_port_hi     = 16'h00F1;

  localparam logic [15:0] keyb_stat_value = 16'h0010;
  localparam logic [15:0] irq_vec_base    = 16'h0008;

endpackage
